// File: all.f
counter_pkg.sv
tag_lane_mapper.sv
window_splitter.sv
lane_counter.sv
tag_counter_top.sv
tb_tag_counter.sv

// File: counter_pkg.sv
package counter_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // tag word layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int CHANNEL_WIDTH = 6;       // 64 input channels
    localparam int TIME_WIDTH    = 56;      // picoseconds
    localparam int TAG_WIDTH     = 64;      // kind + channel + time
    localparam int LOST_WIDTH    = 6;       // saturated lost-tag count in an overflow marker

    // kind codes, top two bits of every tag word
    localparam logic [1:0] TAG_KIND_EVENT    = 2'b01;
    localparam logic [1:0] TAG_KIND_OVERFLOW = 2'b10;

    ////////////////////////////////////////////////////////////////////////////
    // lanes and counts
    ////////////////////////////////////////////////////////////////////////////

    localparam int LANE_WIDTH = 6;
    localparam logic [LANE_WIDTH-1:0] LANE_INVALID = '1;  // channel not counted
    localparam int COUNT_WIDTH = 32;

    // one tag word, read either as a detector event or as an overflow marker
    // kind and stamp sit at the same bits in both views
    typedef union packed {
        struct packed {
            logic [1:0]               kind;
            logic [CHANNEL_WIDTH-1:0] channel;
            logic [TIME_WIDTH-1:0]    stamp;
        } evt;
        struct packed {
            logic [1:0]               kind;
            logic [LOST_WIDTH-1:0]    lost;     // tags dropped upstream
            logic [TIME_WIDTH-1:0]    stamp;
        } ovf;
    } tag_word_u;

endpackage

// File: lane_counter.sv
`timescale 1ns/1ps

module lane_counter
    import counter_pkg::*;
#(
    parameter int WORD_WIDTH = 4,
    parameter int NUM_LANES  = 4
) (
    input  logic                              detector_i,
    input  logic                              rst_n_i,
    input  logic                              start_counting_i,
    input  logic [WORD_WIDTH*LANE_WIDTH-1:0]  slot_lane_i,
    input  logic [WORD_WIDTH-1:0]             slot_valid_i,
    input  logic [WORD_WIDTH-1:0]             slot_overflow_i,
    input  logic [WORD_WIDTH-1:0]             slot_new_window_i,
    input  logic                              word_valid_i,
    input  logic                              close_i,
    input  logic [TIME_WIDTH-1:0]             closed_index_i,
    output logic [NUM_LANES*COUNT_WIDTH-1:0]  count_data_o,
    output logic [TIME_WIDTH-1:0]             window_index_o,
    output logic                              overflow_o,
    output logic                              count_valid_o
);

    localparam int SLOT_CNT_W = $clog2(WORD_WIDTH + 1);  // holds 0..WORD_WIDTH

    logic [SLOT_CNT_W-1:0]  pre_d   [NUM_LANES];  // before the split
    logic [SLOT_CNT_W-1:0]  post_d  [NUM_LANES];  // after the split
    logic [SLOT_CNT_W-1:0]  pre_q   [NUM_LANES];
    logic [SLOT_CNT_W-1:0]  post_q  [NUM_LANES];
    logic                   ovf_pre_d;
    logic                   ovf_post_d;
    logic                   ovf_pre_q;
    logic                   ovf_post_q;
    logic                   stage_valid_q;
    logic                   close_q;
    logic [TIME_WIDTH-1:0]  closed_index_q;
    logic [COUNT_WIDTH-1:0] acc     [NUM_LANES];  // open window totals
    logic                   ovf_acc;

    function automatic logic [COUNT_WIDTH-1:0] sat_add(
        input logic [COUNT_WIDTH-1:0] a,
        input logic [SLOT_CNT_W-1:0]  b
    );
        logic [COUNT_WIDTH:0] sum;
        sum = {1'b0, a} + b;
        return sum[COUNT_WIDTH] ? '1 : sum[COUNT_WIDTH-1:0];  // stick at all ones
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage 1: split counts of one word
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin : p_split_count
        logic [LANE_WIDTH-1:0] lane;
        ovf_pre_d  = 1'b0;
        ovf_post_d = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            pre_d[l]  = '0;
            post_d[l] = '0;
        end
        for (int s = 0; s < WORD_WIDTH; s++) begin
            lane = slot_lane_i[s*LANE_WIDTH +: LANE_WIDTH];
            if (slot_valid_i[s] && slot_overflow_i[s]) begin
                if (slot_new_window_i[s]) ovf_post_d = 1'b1;
                else                      ovf_pre_d  = 1'b1;
            end else if (slot_valid_i[s]) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (lane == LANE_WIDTH'(l)) begin
                        if (slot_new_window_i[s]) post_d[l] = post_d[l] + 1'b1;
                        else                      pre_d[l]  = pre_d[l] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge detector_i) begin
        if (!rst_n_i || !start_counting_i) begin
            stage_valid_q <= 1'b0;
            close_q       <= 1'b0;
        end else begin
            stage_valid_q <= word_valid_i;
            close_q       <= word_valid_i && close_i;
        end
    end

    always_ff @(posedge detector_i) begin
        pre_q          <= pre_d;
        post_q         <= post_d;
        ovf_pre_q      <= ovf_pre_d;
        ovf_post_q     <= ovf_post_d;
        closed_index_q <= closed_index_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2: accumulate and emit
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge detector_i) begin
        if (!rst_n_i) begin
            count_data_o   <= '0;
            window_index_o <= '0;
            overflow_o     <= 1'b0;
            count_valid_o  <= 1'b0;
            ovf_acc        <= 1'b0;
            for (int l = 0; l < NUM_LANES; l++) acc[l] <= '0;
        end else if (!start_counting_i) begin  // open window thrown away, no output
            count_valid_o <= 1'b0;
            ovf_acc       <= 1'b0;
            for (int l = 0; l < NUM_LANES; l++) acc[l] <= '0;
        end else begin
            count_valid_o <= 1'b0;
            if (stage_valid_q && close_q) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    count_data_o[l*COUNT_WIDTH +: COUNT_WIDTH] <= sat_add(acc[l], pre_q[l]);
                    acc[l] <= COUNT_WIDTH'(post_q[l]);  // later tags open the next window
                end
                overflow_o     <= ovf_acc | ovf_pre_q;
                ovf_acc        <= ovf_post_q;
                window_index_o <= closed_index_q;
                count_valid_o  <= 1'b1;
            end else if (stage_valid_q) begin
                for (int l = 0; l < NUM_LANES; l++) acc[l] <= sat_add(acc[l], pre_q[l]);
                ovf_acc <= ovf_acc | ovf_pre_q;
            end
        end
    end

    // back to back results come from consecutive closing words, each one a later window
    a_result_index_rising : assert property (
        @(posedge detector_i) disable iff (!rst_n_i)
        count_valid_o |=> !count_valid_o || (window_index_o > $past(window_index_o))
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the tag counter testbench with Verilator and run it
# the exit status is the simulation's own

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_tag_counter -Mdir obj_dir &&
./obj_dir/Vtb_tag_counter || exit 1

// File: tag_counter_top.sv
`timescale 1ns/1ps

module tag_counter_top
    import counter_pkg::*;
#(
    parameter int WORD_WIDTH = 4,
    parameter int NUM_LANES  = 4   // at most 63, the all-ones lane is reserved
) (
    input  logic                             detector_i,
    input  logic                             rst_n_i,
    input  logic [WORD_WIDTH*TAG_WIDTH-1:0]  tags_i,
    input  logic                             tags_valid_i,
    input  logic [WORD_WIDTH-1:0]            tag_slot_valid_i,
    input  logic                             start_counting_i,
    input  logic [5:0]                       window_log2_i,
    input  logic                             lut_we_i,
    input  logic [CHANNEL_WIDTH-1:0]         lut_addr_i,
    input  logic [LANE_WIDTH-1:0]            lut_lane_i,
    output logic [NUM_LANES*COUNT_WIDTH-1:0] count_data_o,
    output logic [TIME_WIDTH-1:0]            window_index_o,
    output logic                             overflow_o,
    output logic                             count_valid_o
);

    ////////////////////////////////////////////////////////////////////////////
    // mapper -> splitter
    ////////////////////////////////////////////////////////////////////////////

    logic [WORD_WIDTH*LANE_WIDTH-1:0] map_lane;
    logic [WORD_WIDTH-1:0]            map_valid;
    logic [WORD_WIDTH-1:0]            map_overflow;
    logic [WORD_WIDTH*TIME_WIDTH-1:0] map_time;
    logic                             map_word_valid;

    // splitter -> counter
    logic [WORD_WIDTH*LANE_WIDTH-1:0] spl_lane;
    logic [WORD_WIDTH-1:0]            spl_valid;
    logic [WORD_WIDTH-1:0]            spl_overflow;
    logic [WORD_WIDTH-1:0]            spl_new_window;
    logic                             spl_word_valid;
    logic                             spl_close;
    logic [TIME_WIDTH-1:0]            spl_closed_index;

    tag_lane_mapper #(
        .WORD_WIDTH(WORD_WIDTH),
        .NUM_LANES (NUM_LANES)
    ) i_mapper (
        .detector_i      (detector_i),
        .rst_n_i         (rst_n_i),
        .tags_i          (tags_i),
        .tags_valid_i    (tags_valid_i),
        .tag_slot_valid_i(tag_slot_valid_i),
        .start_counting_i(start_counting_i),
        .lut_we_i        (lut_we_i),
        .lut_addr_i      (lut_addr_i),
        .lut_lane_i      (lut_lane_i),
        .slot_lane_o     (map_lane),
        .slot_valid_o    (map_valid),
        .slot_overflow_o (map_overflow),
        .slot_time_o     (map_time),
        .word_valid_o    (map_word_valid)
    );

    window_splitter #(
        .WORD_WIDTH(WORD_WIDTH)
    ) i_splitter (
        .detector_i       (detector_i),
        .rst_n_i          (rst_n_i),
        .start_counting_i (start_counting_i),
        .window_log2_i    (window_log2_i),
        .slot_lane_i      (map_lane),
        .slot_valid_i     (map_valid),
        .slot_overflow_i  (map_overflow),
        .slot_time_i      (map_time),
        .word_valid_i     (map_word_valid),
        .slot_lane_o      (spl_lane),
        .slot_valid_o     (spl_valid),
        .slot_overflow_o  (spl_overflow),
        .slot_new_window_o(spl_new_window),
        .word_valid_o     (spl_word_valid),
        .close_o          (spl_close),
        .closed_index_o   (spl_closed_index)
    );

    lane_counter #(
        .WORD_WIDTH(WORD_WIDTH),
        .NUM_LANES (NUM_LANES)
    ) i_counter (
        .detector_i       (detector_i),
        .rst_n_i          (rst_n_i),
        .start_counting_i (start_counting_i),
        .slot_lane_i      (spl_lane),
        .slot_valid_i     (spl_valid),
        .slot_overflow_i  (spl_overflow),
        .slot_new_window_i(spl_new_window),
        .word_valid_i     (spl_word_valid),
        .close_i          (spl_close),
        .closed_index_i   (spl_closed_index),
        .count_data_o     (count_data_o),
        .window_index_o   (window_index_o),
        .overflow_o       (overflow_o),
        .count_valid_o    (count_valid_o)
    );

endmodule

// File: tag_lane_mapper.sv
`timescale 1ns/1ps

module tag_lane_mapper
    import counter_pkg::*;
#(
    parameter int WORD_WIDTH = 4,
    parameter int NUM_LANES  = 4
) (
    input  logic                             detector_i,
    input  logic                             rst_n_i,
    input  logic [WORD_WIDTH*TAG_WIDTH-1:0]  tags_i,
    input  logic                             tags_valid_i,
    input  logic [WORD_WIDTH-1:0]            tag_slot_valid_i,
    input  logic                             start_counting_i,
    input  logic                             lut_we_i,
    input  logic [CHANNEL_WIDTH-1:0]         lut_addr_i,
    input  logic [LANE_WIDTH-1:0]            lut_lane_i,
    output logic [WORD_WIDTH*LANE_WIDTH-1:0] slot_lane_o,
    output logic [WORD_WIDTH-1:0]            slot_valid_o,
    output logic [WORD_WIDTH-1:0]            slot_overflow_o,
    output logic [WORD_WIDTH*TIME_WIDTH-1:0] slot_time_o,
    output logic                             word_valid_o
);

    localparam int LUT_DEPTH = 2**CHANNEL_WIDTH;

    logic [LANE_WIDTH-1:0] lut    [LUT_DEPTH];   // channel -> lane
    tag_word_u             tag_w  [WORD_WIDTH];  // decoded slots
    logic [LANE_WIDTH-1:0] lane_w [WORD_WIDTH];
    logic [WORD_WIDTH-1:0] ovf_w;                // slot is an overflow marker
    logic [WORD_WIDTH-1:0] keep_w;               // slot survives mapping

    ////////////////////////////////////////////////////////////////////////////
    // lookup table
    ////////////////////////////////////////////////////////////////////////////

    // write lands at the edge, so the next presented word already sees it
    always_ff @(posedge detector_i) begin
        if (!rst_n_i) begin
            for (int c = 0; c < LUT_DEPTH; c++) begin
                lut[c] <= LANE_INVALID;  // nothing counted after reset
            end
        end else if (lut_we_i) begin
            lut[lut_addr_i] <= lut_lane_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // slot decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < WORD_WIDTH; s++) begin
            tag_w[s]  = tags_i[s*TAG_WIDTH +: TAG_WIDTH];
            lane_w[s] = lut[tag_w[s].evt.channel];
            ovf_w[s]  = (tag_w[s].ovf.kind == TAG_KIND_OVERFLOW);
            // events need a real lane, markers pass as long as counting runs
            keep_w[s] = tags_valid_i && tag_slot_valid_i[s] && start_counting_i
                        && (ovf_w[s] || (tag_w[s].evt.kind == TAG_KIND_EVENT
                                         && lane_w[s] < LANE_WIDTH'(NUM_LANES)));
        end
    end

    // control
    always_ff @(posedge detector_i) begin
        if (!rst_n_i) begin
            slot_valid_o <= '0;
            word_valid_o <= 1'b0;
        end else begin
            slot_valid_o <= keep_w;
            word_valid_o <= tags_valid_i && start_counting_i;
        end
    end

    // payload, qualified by slot_valid_o downstream
    always_ff @(posedge detector_i) begin
        for (int s = 0; s < WORD_WIDTH; s++) begin
            slot_lane_o[s*LANE_WIDTH +: LANE_WIDTH] <= ovf_w[s] ? LANE_INVALID : lane_w[s];
            slot_time_o[s*TIME_WIDTH +: TIME_WIDTH] <= tag_w[s].evt.stamp;  // same bits in ovf view
        end
        slot_overflow_o <= ovf_w;
    end

    // LUT writes come from the register side and must name a known channel
    a_lut_write_in_range : assert property (
        @(posedge detector_i) disable iff (!rst_n_i)
        lut_we_i |-> !$isunknown(lut_addr_i)
    );

endmodule

// File: tb_tag_counter.sv
`timescale 1ns/1ps

module tb_tag_counter
    import counter_pkg::*;
();

    localparam int WORD_WIDTH = 4;
    localparam int NUM_LANES  = 4;
    localparam int CHK_W      = NUM_LANES*COUNT_WIDTH;   // widest compared value
    localparam int RST_CYCLES = 5;
    // words per test, idle gaps at most double or triple these
    localparam int N_EMPTY  = 20;
    localparam int N_MAPPED = 30;
    localparam int N_WIN    = 40;
    localparam int N_RAND   = 200;
    localparam int N_STOP   = 12;
    localparam int N_DIRECT = 7;     // straddle and overflow words
    localparam int SETUP    = 16;    // drain, stop and lut writes around a test
    localparam int LIMIT_CYCLES = 2 * (RST_CYCLES + 2*(N_EMPTY + N_MAPPED) + 3*2*N_WIN
                                       + N_RAND + 2*2*N_STOP + N_DIRECT + 10*SETUP);

    logic                             detector_i;
    logic                             rst_n_i;
    logic [WORD_WIDTH*TAG_WIDTH-1:0]  tags_i;
    logic                             tags_valid_i;
    logic [WORD_WIDTH-1:0]            tag_slot_valid_i;
    logic                             start_counting_i;
    logic [5:0]                       window_log2_i;
    logic                             lut_we_i;
    logic [CHANNEL_WIDTH-1:0]         lut_addr_i;
    logic [LANE_WIDTH-1:0]            lut_lane_i;
    logic [CHK_W-1:0]                 count_data_o;
    logic [TIME_WIDTH-1:0]            window_index_o;
    logic                             overflow_o;
    logic                             count_valid_o;

    int                    cycle = 0;
    int                    seed = 74682;
    string                 cur_test = "reset";
    logic [TAG_WIDTH-1:0]  tag_buf [WORD_WIDTH];   // next word, slot by slot
    logic [WORD_WIDTH-1:0] slot_buf;
    logic [TIME_WIDTH-1:0] g_time = '0;            // last generated stamp
    bit                    g_fresh;                // next slot opens the first window
    // reference model state
    logic [LANE_WIDTH-1:0] m_lut [2**CHANNEL_WIDTH];
    bit                    m_open;
    logic [TIME_WIDTH-1:0] m_idx;
    int unsigned           m_cnt [NUM_LANES];
    bit                    m_ovf;
    // results still due, oldest first
    int                    exp_cycle [$];
    logic [TIME_WIDTH-1:0] exp_index [$];
    bit                    exp_ovf [$];
    logic [CHK_W-1:0]      exp_counts [$];

    tag_counter_top #(
        .WORD_WIDTH(WORD_WIDTH),
        .NUM_LANES (NUM_LANES)
    ) i_dut (.*);

    initial begin
        detector_i = 1'b0;
        forever #20 detector_i = ~detector_i;   // 40 ns
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [CHK_W-1:0] expv,
                               input logic [CHK_W-1:0] actv);
        assert (actv === expv)
            else report_fail($sformatf("CHECK FAILED %s %s expected %0h actual %0h",
                                       cur_test, what, expv, actv));
    endtask

    always @(posedge detector_i) begin
        cycle <= cycle + 1;
        assert (cycle <= LIMIT_CYCLES)
            else report_fail($sformatf("timeout: test %s still running after %0d cycles",
                                       cur_test, LIMIT_CYCLES));
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge detector_i) begin
        if (count_valid_o) begin
            assert (exp_index.size() != 0)
                else report_fail($sformatf("%s: result pulse while no window was due",
                                           cur_test));
            check_value("cycle", CHK_W'(exp_cycle.pop_front()), CHK_W'(cycle));
            check_value("window index", CHK_W'(exp_index.pop_front()), CHK_W'(window_index_o));
            check_value("overflow", CHK_W'(exp_ovf.pop_front()), CHK_W'(overflow_o));
            check_value("counts", exp_counts.pop_front(), count_data_o);
        end else if (exp_index.size() != 0) begin
            assert (cycle < exp_cycle[0])
                else report_fail($sformatf("%s: window %0h closed but no result came out",
                                           cur_test, exp_index[0]));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model, run once per word as it is driven
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_word();
        logic [TIME_WIDTH-1:0] idx [WORD_WIDTH];
        bit                    vld [WORD_WIDTH];
        logic [1:0]            kind;
        logic [LANE_WIDTH-1:0] lane;
        logic [TIME_WIDTH-1:0] base;
        logic [TIME_WIDTH-1:0] last;
        logic [CHK_W-1:0]      cv;
        int unsigned           pre [NUM_LANES];
        int unsigned           post [NUM_LANES];
        bit                    seen;
        bit                    closing;
        bit                    ovf_pre;
        bit                    ovf_post;
        seen = 1'b0;
        closing = 1'b0;
        ovf_pre = 1'b0;
        ovf_post = 1'b0;
        base = m_idx;
        last = '0;
        pre = '{default: 0};
        post = '{default: 0};
        for (int s = 0; s < WORD_WIDTH; s++) begin
            kind   = tag_buf[s][TAG_WIDTH-1 -: 2];
            lane   = m_lut[tag_buf[s][TIME_WIDTH +: CHANNEL_WIDTH]];
            idx[s] = tag_buf[s][TIME_WIDTH-1:0] >> window_log2_i;
            vld[s] = slot_buf[s] && (kind == TAG_KIND_OVERFLOW
                                     || (kind == TAG_KIND_EVENT && lane < NUM_LANES));
            if (vld[s]) begin
                if (!seen && !m_open) base = idx[s];   // first tag opens, closes nothing
                seen = 1'b1;
                last = idx[s];
            end
        end
        for (int s = 0; s < WORD_WIDTH; s++) begin
            if (vld[s]) begin
                lane = m_lut[tag_buf[s][TIME_WIDTH +: CHANNEL_WIDTH]];
                closing = closing || (idx[s] > base);
                if (tag_buf[s][TAG_WIDTH-1 -: 2] == TAG_KIND_OVERFLOW) begin
                    if (idx[s] > base) ovf_post = 1'b1;
                    else               ovf_pre  = 1'b1;
                end else if (idx[s] > base) post[lane]++;
                else                        pre[lane]++;
            end
        end
        if (closing) begin
            for (int l = 0; l < NUM_LANES; l++) cv[l*COUNT_WIDTH +: COUNT_WIDTH] = m_cnt[l] + pre[l];
            exp_cycle.push_back(cycle + 4);   // sampled next edge, then three more
            exp_index.push_back(base);
            exp_ovf.push_back(m_ovf || ovf_pre);
            exp_counts.push_back(cv);
            m_cnt = post;
            m_ovf = ovf_post;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) m_cnt[l] += pre[l];
            m_ovf = m_ovf || ovf_pre;
        end
        if (seen) begin
            m_open = 1'b1;
            m_idx  = last;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers, all driving on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [TAG_WIDTH-1:0] event_tag(input int ch, input longint t);
        return {TAG_KIND_EVENT, CHANNEL_WIDTH'(ch), TIME_WIDTH'(t)};
    endfunction

    function automatic logic [TAG_WIDTH-1:0] marker_tag(input int lost, input longint t);
        return {TAG_KIND_OVERFLOW, LOST_WIDTH'(lost), TIME_WIDTH'(t)};
    endfunction

    task automatic set_word(input logic [TAG_WIDTH-1:0] t0, input logic [TAG_WIDTH-1:0] t1,
                            input logic [TAG_WIDTH-1:0] t2, input logic [TAG_WIDTH-1:0] t3);
        tag_buf[0] = t0;
        tag_buf[1] = t1;
        tag_buf[2] = t2;
        tag_buf[3] = t3;
        slot_buf   = '1;
    endtask

    task automatic drive_word();
        @(negedge detector_i);
        lut_we_i = 1'b0;
        for (int s = 0; s < WORD_WIDTH; s++) tags_i[s*TAG_WIDTH +: TAG_WIDTH] = tag_buf[s];
        tag_slot_valid_i = slot_buf;
        tags_valid_i     = 1'b1;
        if (start_counting_i) model_word();   // ignored while stopped
    endtask

    task automatic quiet();
        @(negedge detector_i);
        tags_valid_i     = 1'b0;
        tag_slot_valid_i = '0;
        lut_we_i         = 1'b0;
    endtask

    task automatic drain();
        quiet();
        while (exp_index.size() != 0) quiet();
    endtask

    task automatic stop_counting();
        drain();
        start_counting_i = 1'b0;   // open window dropped without a result
        m_open = 1'b0;
        m_ovf  = 1'b0;
        m_cnt  = '{default: 0};
    endtask

    task automatic resume(input logic [5:0] log2);
        quiet();
        window_log2_i    = log2;
        start_counting_i = 1'b1;
        g_fresh          = 1'b1;
    endtask

    // channels 1..4 onto lanes 0..3
    task automatic map_lanes();
        for (int c = 1; c <= NUM_LANES; c++) begin
            quiet();
            lut_we_i   = 1'b1;
            lut_addr_i = CHANNEL_WIDTH'(c);
            lut_lane_i = LANE_WIDTH'(c - 1);
            m_lut[c]   = LANE_WIDTH'(c - 1);
        end
        quiet();
    endtask

    // time ordered words with at most one boundary per word
    // a slot that opens a window is always counted, so words never merge windows
    task automatic gen_words(input int n, input int idle_max, input bit lead_ovf,
                             input int ch_span);
        logic [TIME_WIDTH-1:0] t;
        bit                    crossed;
        bit                    lead;
        for (int w = 0; w < n; w++) begin
            crossed = 1'b0;
            for (int s = 0; s < WORD_WIDTH; s++) begin
                t = g_time + TIME_WIDTH'(rnd(4));
                if (rnd(16) == 0) begin   // jump ahead, leaving empty windows
                    t = ((t >> window_log2_i) + TIME_WIDTH'(1 + rnd(3))) << window_log2_i;
                end
                lead = g_fresh;
                if ((t >> window_log2_i) != (g_time >> window_log2_i)) begin
                    if (crossed) begin
                        t = g_time;   // stay in the window just entered
                    end else begin
                        crossed = 1'b1;
                        lead    = 1'b1;
                    end
                end
                g_fresh = 1'b0;
                if (lead && lead_ovf) tag_buf[s] = marker_tag(rnd(64), t);
                else if (lead)        tag_buf[s] = event_tag(1 + rnd(NUM_LANES), t);
                else                  tag_buf[s] = event_tag(rnd(ch_span), t);
                slot_buf[s] = lead || (rnd(8) != 0);
                g_time = t;
            end
            drive_word();
            repeat (rnd(idle_max + 1)) quiet();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic empty_lut_windows();
        cur_test = "empty_lut_windows";
        resume(5);
        gen_words(N_EMPTY, 1, 1'b1, 64);     // markers open windows, events all dropped
        stop_counting();
        map_lanes();
        resume(5);
        gen_words(N_MAPPED, 1, 1'b0, 8);
        stop_counting();
    endtask

    task automatic window_timing();
        cur_test = "window_timing";
        resume(4);
        gen_words(N_WIN, 2, 1'b0, 8);
        stop_counting();
        resume(9);
        gen_words(N_WIN, 2, 1'b0, 8);
        stop_counting();
    endtask

    task automatic straddle_word();
        cur_test = "straddle_word";
        resume(5);   // 32 ps windows
        set_word(event_tag(1, 10), event_tag(2, 20), event_tag(3, 33), event_tag(3, 40));
        drive_word();
        set_word(event_tag(4, 41), event_tag(1, 70), event_tag(2, 71), event_tag(1, 72));
        drive_word();
        set_word(event_tag(1, 100), event_tag(2, 101), event_tag(3, 102), event_tag(4, 103));
        drive_word();
        stop_counting();
    endtask

    task automatic random_stream();
        cur_test = "random_stream";
        resume(3);
        gen_words(N_RAND, 0, 1'b0, 8);   // back to back
        stop_counting();
    endtask

    task automatic overflow_marker();
        cur_test = "overflow_marker";
        resume(6);   // marker at 70 ps lands in window 1 only
        set_word(event_tag(1, 5), event_tag(2, 10), event_tag(3, 20), event_tag(4, 30));
        drive_word();
        set_word(event_tag(1, 60), marker_tag(3, 70), event_tag(2, 80), event_tag(3, 90));
        drive_word();
        set_word(event_tag(4, 130), event_tag(1, 140), event_tag(2, 150), event_tag(3, 160));
        drive_word();
        set_word(event_tag(1, 200), event_tag(2, 210), event_tag(3, 220), event_tag(4, 230));
        drive_word();
        stop_counting();
    endtask

    task automatic stop_restart();
        cur_test = "stop_restart";
        resume(4);
        gen_words(N_STOP, 1, 1'b0, 8);
        stop_counting();
        set_word(event_tag(1, g_time), event_tag(2, g_time), event_tag(3, g_time),
                 event_tag(4, g_time));
        drive_word();   // dropped, counting is off
        resume(4);
        gen_words(N_STOP, 1, 1'b0, 8);
        stop_counting();
    endtask

    initial begin
        rst_n_i          = 1'b0;
        tags_i           = '0;
        tags_valid_i     = 1'b0;
        tag_slot_valid_i = '0;
        start_counting_i = 1'b0;
        window_log2_i    = '0;
        lut_we_i         = 1'b0;
        lut_addr_i       = '0;
        lut_lane_i       = '0;
        for (int c = 0; c < 2**CHANNEL_WIDTH; c++) m_lut[c] = LANE_INVALID;
        repeat (RST_CYCLES) @(negedge detector_i);
        rst_n_i = 1'b1;
        empty_lut_windows();
        window_timing();
        straddle_word();
        random_stream();
        overflow_marker();
        stop_restart();
        drain();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: window_splitter.sv
`timescale 1ns/1ps

module window_splitter
    import counter_pkg::*;
#(
    parameter int WORD_WIDTH = 4
) (
    input  logic                             detector_i,
    input  logic                             rst_n_i,
    input  logic                             start_counting_i,
    input  logic [5:0]                       window_log2_i,
    input  logic [WORD_WIDTH*LANE_WIDTH-1:0] slot_lane_i,
    input  logic [WORD_WIDTH-1:0]            slot_valid_i,
    input  logic [WORD_WIDTH-1:0]            slot_overflow_i,
    input  logic [WORD_WIDTH*TIME_WIDTH-1:0] slot_time_i,
    input  logic                             word_valid_i,
    output logic [WORD_WIDTH*LANE_WIDTH-1:0] slot_lane_o,
    output logic [WORD_WIDTH-1:0]            slot_valid_o,
    output logic [WORD_WIDTH-1:0]            slot_overflow_o,
    output logic [WORD_WIDTH-1:0]            slot_new_window_o,
    output logic                             word_valid_o,
    output logic                             close_o,
    output logic [TIME_WIDTH-1:0]            closed_index_o
);

    logic                  win_open;                 // a window is being counted
    logic [TIME_WIDTH-1:0] open_idx;                 // its index
    logic [TIME_WIDTH-1:0] slot_idx [WORD_WIDTH];
    logic [WORD_WIDTH-1:0] valid_w;
    logic                  any_valid;
    logic [TIME_WIDTH-1:0] first_idx;                // index of first valid slot
    logic [TIME_WIDTH-1:0] last_idx;                 // index of last valid slot
    logic [TIME_WIDTH-1:0] base_idx;                 // window the word is compared to
    logic [WORD_WIDTH-1:0] new_w;                    // slot belongs to a later window
    logic                  span_ok;

    ////////////////////////////////////////////////////////////////////////////
    // per-slot window index
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        valid_w   = slot_valid_i & {WORD_WIDTH{word_valid_i}};
        any_valid = 1'b0;
        first_idx = '0;
        last_idx  = '0;
        for (int s = 0; s < WORD_WIDTH; s++) begin
            slot_idx[s] = slot_time_i[s*TIME_WIDTH +: TIME_WIDTH] >> window_log2_i;
            if (valid_w[s]) begin
                if (!any_valid) first_idx = slot_idx[s];
                last_idx  = slot_idx[s];  // tags are time ordered, so this is the max
                any_valid = 1'b1;
            end
        end
        // first tag after start opens its own window, closing nothing
        base_idx = win_open ? open_idx : first_idx;
        span_ok  = 1'b1;
        for (int s = 0; s < WORD_WIDTH; s++) begin
            new_w[s] = valid_w[s] && (slot_idx[s] > base_idx);
            if (valid_w[s] && slot_idx[s] != first_idx && slot_idx[s] != last_idx) begin
                span_ok = 1'b0;  // a third index inside one word
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // open window tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge detector_i) begin
        if (!rst_n_i || !start_counting_i) begin  // stop drops the open window
            win_open     <= 1'b0;
            open_idx     <= '0;
            slot_valid_o <= '0;
            word_valid_o <= 1'b0;
            close_o      <= 1'b0;
        end else begin
            slot_valid_o <= valid_w;
            word_valid_o <= word_valid_i;
            close_o      <= |new_w;
            if (any_valid) begin
                win_open <= 1'b1;
                open_idx <= last_idx;  // adopt the later window
            end
        end
    end

    always_ff @(posedge detector_i) begin
        slot_lane_o       <= slot_lane_i;
        slot_overflow_o   <= slot_overflow_i;
        slot_new_window_o <= new_w;
        closed_index_o    <= base_idx;
    end

    // upstream promise: one word never reaches past the next window
    a_word_two_windows : assert property (
        @(posedge detector_i) disable iff (!rst_n_i || !start_counting_i)
        word_valid_i |-> span_ok
    );

    // tag time only moves forward, word to word
    a_index_monotonic : assert property (
        @(posedge detector_i) disable iff (!rst_n_i || !start_counting_i)
        (word_valid_i && any_valid && win_open) |-> (first_idx >= open_idx)
    );

endmodule
